/* src/box_cfg.svh */
`ifndef BOX_CFG_SVH
`define BOX_CFG_SVH

// Image geometry, fixed per build.
`define BOX_IMG_COLS 32
`define BOX_IMG_ROWS 24

// Window shape. The column datapath is built for a radius of 8.
`define BOX_RADIUS   8
`define BOX_WIN      (2 * `BOX_RADIUS + 1)
`define BOX_WIN_AREA (`BOX_WIN * `BOX_WIN)

`define BOX_COL_W    10 // Row and column counter width.

// APB register map.
`define BOX_ADDR_CTRL   4'h0
`define BOX_ADDR_OFFSET 4'h4
`define BOX_ADDR_STATUS 4'h8

`endif

/* src/box_pkg.sv */
`include "box_cfg.svh"

package box_pkg;

    typedef struct packed {
        logic [`BOX_COL_W-1:0] row;
        logic [`BOX_COL_W-1:0] col;
        logic                  row_start; // First pixel of a line.
        logic                  win_valid; // Window fully inside the image.
    } pix_tag_t;

    // Sample 0 is the oldest row, the last one is the current pixel.
    typedef struct packed {
        logic [`BOX_WIN-1:0][7:0] samp;
        pix_tag_t                 tag;
    } column_t;

    typedef struct packed {
        logic [12:0] sum;
        pix_tag_t    tag;
    } col_sum_t;

    typedef struct packed {
        logic [16:0]           sum;
        logic [7:0]            centre;
        logic                  bin;
        logic [`BOX_COL_W-1:0] row;
        logic [`BOX_COL_W-1:0] col;
    } win_result_t;

    typedef struct packed {
        logic [3:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_DONE
    } frame_state_e;

    typedef enum logic [3:0] {
        REG_CTRL   = `BOX_ADDR_CTRL,
        REG_OFFSET = `BOX_ADDR_OFFSET,
        REG_STATUS = `BOX_ADDR_STATUS
    } reg_addr_e;

endpackage

/* src/frame_ctrl.sv */
`timescale 1ns/1ps
`include "box_cfg.svh"

module frame_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_enable,
    input  logic              i_pix_valid,
    output box_pkg::pix_tag_t o_tag,
    output logic              o_pix_valid,
    output logic              o_frame_done
);
    import box_pkg::*;

    localparam int CW = `BOX_COL_W;

    frame_state_e  state_q;
    logic [CW-1:0] row_q;
    logic [CW-1:0] col_q;
    logic          accept;
    logic          last_col;
    logic          last_pix;

    assign accept   = i_enable & i_pix_valid; // Strobes ignored while disabled.
    assign last_col = (col_q == CW'(`BOX_IMG_COLS - 1));
    assign last_pix = last_col && (row_q == CW'(`BOX_IMG_ROWS - 1));

    // Raster position of the next accepted pixel.
    always_ff @(posedge clk) begin
        if (rst) begin
            row_q <= '0;
            col_q <= '0;
        end else if (accept) begin
            if (last_col) begin
                col_q <= '0;
                row_q <= last_pix ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= last_pix ? ST_DONE : ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (accept && last_pix) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: state_q <= accept ? ST_ACTIVE : ST_IDLE; // Back-to-back frames.
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign o_frame_done = (state_q == ST_DONE);
    assign o_pix_valid  = accept;
    assign o_tag = '{
        row:       row_q,
        col:       col_q,
        row_start: (col_q == '0),
        win_valid: (row_q >= CW'(`BOX_WIN - 1)) && (col_q >= CW'(`BOX_WIN - 1))
    };

    a_pos_in_bounds: assert property (@(posedge clk) disable iff (rst)
        accept |=> (row_q < `BOX_IMG_ROWS) && (col_q < `BOX_IMG_COLS))
        else $error("frame_ctrl position out of bounds row=%0d col=%0d", row_q, col_q);

endmodule

/* src/line_buffer.sv */
`timescale 1ns/1ps
`include "box_cfg.svh"

module line_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_pix_valid,
    input  logic [7:0]        i_pix,
    input  box_pkg::pix_tag_t i_tag,
    output logic              o_col_valid,
    output box_pkg::column_t  o_col
);
    localparam int LINES = `BOX_WIN - 1;
    localparam int AW    = $clog2(`BOX_IMG_COLS);

    // Line k holds the row k+1 above the current one.
    logic [7:0] line_mem [LINES][`BOX_IMG_COLS];
    logic [4:0] lines_seen;
    logic [AW-1:0] wr_col;

    assign wr_col = i_tag.col[AW-1:0];

    // Each strobe pushes its column one line further down.
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            line_mem[0][wr_col] <= i_pix;
            for (int k = 1; k < LINES; k++) begin
                line_mem[k][wr_col] <= line_mem[k-1][wr_col];
            end
        end
    end

    // Counts completed lines so unwritten memory reads as zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            lines_seen <= '0;
        end else if (i_pix_valid && (i_tag.col == `BOX_IMG_COLS - 1)
                     && (lines_seen != 5'(LINES))) begin
            lines_seen <= lines_seen + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_col_valid <= 1'b0;
        end else begin
            o_col_valid <= i_pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            o_col.tag         <= i_tag;
            o_col.samp[LINES] <= i_pix; // Newest sample.
            for (int k = 0; k < LINES; k++) begin
                o_col.samp[LINES-1-k] <= (k < lines_seen) ? line_mem[k][wr_col] : 8'd0;
            end
        end
    end

    a_col_in_range: assert property (@(posedge clk) disable iff (rst)
        i_pix_valid |-> (i_tag.col < `BOX_IMG_COLS))
        else $error("line_buffer column tag %0d out of range", i_tag.col);

endmodule

/* src/column_adder.sv */
`timescale 1ns/1ps
`include "box_cfg.svh"

module column_adder (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_col_valid,
    input  box_pkg::column_t  i_col,
    output logic              o_sum_valid,
    output box_pkg::col_sum_t o_sum,
    output logic [7:0]        o_centre
);
    import box_pkg::*;

    localparam int DEPTH  = 5;
    localparam int CENTRE = `BOX_RADIUS;
    localparam int LAST   = `BOX_WIN - 1;

    logic [7:0][8:0]       lvl1;
    logic [3:0][9:0]       lvl2;
    logic [1:0][10:0]      lvl3;
    logic [11:0]           lvl4;
    logic [12:0]           lvl5;
    logic [DEPTH-2:0][7:0] last_pipe; // Odd sample waits for the tree.
    logic [DEPTH-1:0]      valid_pipe;
    pix_tag_t              tag_pipe [DEPTH];
    logic [7:0]            centre_pipe [DEPTH];

    // Pairwise tree over samples 0..15, one register per level.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            lvl1[i] <= {1'b0, i_col.samp[2*i]} + {1'b0, i_col.samp[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            lvl2[i] <= {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            lvl3[i] <= {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
        end
        lvl4 <= {1'b0, lvl3[0]} + {1'b0, lvl3[1]};
        lvl5 <= {1'b0, lvl4} + {5'b0, last_pipe[DEPTH-2]};
    end

    always_ff @(posedge clk) begin
        last_pipe[0]   <= i_col.samp[LAST];
        tag_pipe[0]    <= i_col.tag;
        centre_pipe[0] <= i_col.samp[CENTRE];
        for (int i = 1; i < DEPTH - 1; i++) begin
            last_pipe[i] <= last_pipe[i-1];
        end
        for (int i = 1; i < DEPTH; i++) begin
            tag_pipe[i]    <= tag_pipe[i-1];
            centre_pipe[i] <= centre_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[DEPTH-2:0], i_col_valid};
        end
    end

    assign o_sum_valid = valid_pipe[DEPTH-1];
    assign o_sum       = '{sum: lvl5, tag: tag_pipe[DEPTH-1]};
    assign o_centre    = centre_pipe[DEPTH-1];

endmodule

/* src/window_accumulator.sv */
`timescale 1ns/1ps
`include "box_cfg.svh"

module window_accumulator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_sum_valid,
    input  box_pkg::col_sum_t    i_sum,
    input  logic [7:0]           i_centre,
    input  logic signed [7:0]    i_offset,
    output logic                 o_out_valid,
    output box_pkg::win_result_t o_out
);
    import box_pkg::*;

    localparam int                    HIST    = `BOX_WIN;
    localparam int                    CDLY    = `BOX_RADIUS;
    localparam logic [16:0]           MAX_SUM = `BOX_WIN_AREA * 255;
    localparam logic signed [21:0]    AREA    = `BOX_WIN_AREA;
    localparam logic [`BOX_COL_W-1:0] RAD     = `BOX_RADIUS;

    logic [12:0]        hist [HIST];  // Entry 0 is the latest column.
    logic [7:0]         cdly [CDLY];
    logic [16:0]        run_sum;
    logic [16:0]        next_sum;
    logic               s1_valid;
    pix_tag_t           s1_tag;
    logic [7:0]         s1_centre;
    logic signed [10:0] pix_off;
    logic signed [21:0] thr;

    // Drop the column leaving the window, add the new one.
    assign next_sum = (i_sum.tag.row_start ? 17'd0 : run_sum - {4'b0, hist[HIST-1]})
                      + {4'b0, i_sum.sum};

    always_ff @(posedge clk) begin
        if (rst) begin
            run_sum  <= '0;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= i_sum_valid & i_sum.tag.win_valid;
            if (i_sum_valid) begin
                run_sum <= next_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_sum_valid) begin
            hist[0] <= i_sum.sum;
            for (int i = 1; i < HIST; i++) begin
                hist[i] <= i_sum.tag.row_start ? 13'd0 : hist[i-1];
            end
            cdly[0] <= i_centre;
            for (int i = 1; i < CDLY; i++) begin
                cdly[i] <= cdly[i-1];
            end
            s1_tag    <= i_sum.tag;
            s1_centre <= cdly[CDLY-1]; // Centre column is 8 behind.
        end
    end

    // Threshold compare, scaled by the area to avoid a divide.
    assign pix_off = $signed({3'b000, s1_centre}) + i_offset;
    assign thr     = pix_off * AREA;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            o_out.sum    <= run_sum;
            o_out.centre <= s1_centre;
            o_out.bin    <= (thr >= $signed({5'b0, run_sum}));
            o_out.row    <= s1_tag.row - RAD;
            o_out.col    <= s1_tag.col - RAD;
        end
    end

    a_sum_bounded: assert property (@(posedge clk) disable iff (rst)
        i_sum_valid |=> (run_sum <= MAX_SUM))
        else $error("window_accumulator running sum overflow %0h", run_sum);

endmodule

/* src/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs (
    input  logic              clk,
    input  logic              rst,
    input  box_pkg::apb_req_t i_apb,
    output box_pkg::apb_rsp_t o_apb,
    input  logic              i_out_valid,
    input  logic              i_frame_done,
    output logic              o_enable,
    output logic signed [7:0] o_offset
);
    import box_pkg::*;

    localparam int DONE_BIT = 16;

    reg_addr_e   addr;
    logic        access;
    logic        mapped;
    logic        wr_en;
    logic        status_clr;
    logic [31:0] rdata;
    logic        ctrl_en;
    logic [7:0]  offset_q;
    logic [15:0] count_q;
    logic        done_q;

    assign addr   = reg_addr_e'(i_apb.paddr);
    assign access = i_apb.psel & i_apb.penable;
    assign wr_en  = access & i_apb.pwrite & mapped;
    assign status_clr = wr_en && (addr == REG_STATUS) && i_apb.pwdata[DONE_BIT];

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (addr)
            REG_CTRL:   rdata = {31'b0, ctrl_en};
            REG_OFFSET: rdata = {24'b0, offset_q};
            REG_STATUS: rdata = {15'b0, done_q, count_q};
            default:    mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_en  <= 1'b0;
            offset_q <= '0;
        end else if (wr_en) begin
            if (addr == REG_CTRL) begin
                ctrl_en <= i_apb.pwdata[0];
            end
            if (addr == REG_OFFSET) begin
                offset_q <= i_apb.pwdata[7:0];
            end
        end
    end

    // Output count and sticky done, write one to clear.
    always_ff @(posedge clk) begin
        if (rst || status_clr) begin
            count_q <= '0;
            done_q  <= 1'b0;
        end else begin
            if (i_out_valid) begin
                count_q <= count_q + 1'b1;
            end
            if (i_frame_done) begin
                done_q <= 1'b1;
            end
        end
    end

    assign o_apb    = '{prdata: rdata, pready: 1'b1, pslverr: access & ~mapped};
    assign o_enable = ctrl_en;
    assign o_offset = offset_q;

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
        i_apb.penable |-> i_apb.psel)
        else $error("apb_regs penable without psel");

endmodule

/* src/adaptive_threshold_top.sv */
`timescale 1ns/1ps

module adaptive_threshold_top (
    input  logic                 clk,
    input  logic                 rst,
    input  box_pkg::apb_req_t    i_apb,
    output box_pkg::apb_rsp_t    o_apb,
    input  logic                 i_pix_valid,
    input  logic [7:0]           i_pix,
    output logic                 o_out_valid,
    output box_pkg::win_result_t o_out
);
    import box_pkg::*;

    logic              enable;
    logic signed [7:0] offset;
    logic              frame_done;
    pix_tag_t          tag;
    logic              pix_valid;
    logic              col_valid;
    column_t           col;
    logic              sum_valid;
    col_sum_t          col_sum;
    logic [7:0]        centre;

    frame_ctrl u_frame_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_enable     (enable),
        .i_pix_valid  (i_pix_valid),
        .o_tag        (tag),
        .o_pix_valid  (pix_valid),
        .o_frame_done (frame_done)
    );

    line_buffer u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (pix_valid),
        .i_pix       (i_pix),
        .i_tag       (tag),
        .o_col_valid (col_valid),
        .o_col       (col)
    );

    column_adder u_column_adder (
        .clk         (clk),
        .rst         (rst),
        .i_col_valid (col_valid),
        .i_col       (col),
        .o_sum_valid (sum_valid),
        .o_sum       (col_sum),
        .o_centre    (centre)
    );

    window_accumulator u_window_accumulator (
        .clk         (clk),
        .rst         (rst),
        .i_sum_valid (sum_valid),
        .i_sum       (col_sum),
        .i_centre    (centre),
        .i_offset    (offset),
        .o_out_valid (o_out_valid),
        .o_out       (o_out)
    );

    apb_regs u_apb_regs (
        .clk          (clk),
        .rst          (rst),
        .i_apb        (i_apb),
        .o_apb        (o_apb),
        .i_out_valid  (o_out_valid),
        .i_frame_done (frame_done),
        .o_enable     (enable),
        .o_offset     (offset)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    localparam int HALF_NS    = 10; // 20 ns period.
    localparam int RST_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps
`include "box_cfg.svh"

module tb_top;
    import box_pkg::*;

    localparam int ROWS        = `BOX_IMG_ROWS;
    localparam int COLS        = `BOX_IMG_COLS;
    localparam int EDGE        = `BOX_WIN - 1;
    localparam int NRES        = (ROWS - EDGE) * (COLS - EDGE);
    localparam int FRAMES      = 3;
    localparam int MAX_GAP     = 3;
    localparam int WATCHDOG_NS = FRAMES * ROWS * COLS * (MAX_GAP + 1) * 20 + 100000;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        pix_valid;
    logic [7:0]  pix;
    logic        out_valid;
    win_result_t out_res;
    logic        drv_win;          // Current strobe completes a window.
    logic [7:0]  win_pipe;
    logic [15:0] lfsr_q = 16'd10;
    logic [7:0]  img [ROWS][COLS];
    win_result_t exp_q [$];

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    adaptive_threshold_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .i_apb       (apb_req),
        .o_apb       (apb_rsp),
        .i_pix_valid (pix_valid),
        .i_pix       (pix),
        .o_out_valid (out_valid),
        .o_out       (out_res)
    );

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        a_value: assert (got == exp) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit drawn.
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk); // Access phase completes here.
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_value("pslverr", err, 32'h0);
    endtask

    task automatic reg_expect(input string name, input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check_value("pslverr", err, 32'h0);
        check_value(name, rd, exp);
    endtask

    // Random image and its 17x17 reference results in raster order.
    task automatic fill_frame(input logic signed [7:0] offset);
        win_result_t r;
        int          sum;
        int          ctr;
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                img[y][x] = take_bits(8);
            end
        end
        for (int y = EDGE; y < ROWS; y++) begin
            for (int x = EDGE; x < COLS; x++) begin
                sum = 0;
                for (int dy = 0; dy <= EDGE; dy++) begin
                    for (int dx = 0; dx <= EDGE; dx++) begin
                        sum += img[y-dy][x-dx];
                    end
                end
                ctr      = img[y-`BOX_RADIUS][x-`BOX_RADIUS];
                r.sum    = sum[16:0];
                r.centre = ctr[7:0];
                r.bin    = ((ctr + int'(offset)) * `BOX_WIN_AREA) >= sum;
                r.row    = 10'(y - `BOX_RADIUS);
                r.col    = 10'(x - `BOX_RADIUS);
                exp_q.push_back(r);
            end
        end
    endtask

    task automatic send_pixel(input logic [7:0] p, input logic completes);
        int gap;
        gap = take_bits(2); // 0 to MAX_GAP idle cycles.
        repeat (gap) begin
            @(posedge clk);
            pix_valid <= 1'b0;
            drv_win   <= 1'b0;
        end
        @(posedge clk);
        pix_valid <= 1'b1;
        pix       <= p;
        drv_win   <= completes;
    endtask

    task automatic end_stream();
        @(posedge clk);
        pix_valid <= 1'b0;
        drv_win   <= 1'b0;
    endtask

    task automatic drive_disabled(input int n);
        repeat (n) send_pixel(take_bits(8), 1'b0);
        end_stream();
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 64) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out waiting for %0d window results", exp_q.size());
            stop_on_error();
        end
    endtask

    // Result checker, one record per valid cycle.
    always @(posedge clk) begin
        win_result_t e;
        if (rst) begin
            win_pipe <= '0;
        end else begin
            win_pipe <= {win_pipe[6:0], drv_win};
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A window result arrived when none was expected");
                    stop_on_error();
                end else begin
                    e = exp_q.pop_front();
                    check_value("o_out.sum", out_res.sum, e.sum);
                    check_value("o_out.centre", out_res.centre, e.centre);
                    check_value("o_out.bin", out_res.bin, e.bin);
                    check_value("o_out.row", out_res.row, e.row);
                    check_value("o_out.col", out_res.col, e.col);
                end
            end
        end
    end

    // Output valid exactly 8 cycles after the completing strobe.
    a_out_timing: assert property (@(posedge clk) disable iff (rst) out_valid == win_pipe[7])
        else begin
            $display("FAIL o_out_valid got 0x%0h expected 0x%0h", out_valid, win_pipe[7]);
            stop_on_error();
        end

    a_pready: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
        else begin
            $display("APB pready went low during a transfer");
            stop_on_error();
        end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        stop_on_error();
    end

    initial begin
        logic [31:0]       rd;
        logic              err;
        logic signed [7:0] offs [FRAMES];
        offs = '{8'sd0, 8'sd12, -8'sd9};
        apb_req   <= '0;
        pix_valid <= 1'b0;
        pix       <= 8'h00;
        drv_win   <= 1'b0;
        while (rst !== 1'b0) @(posedge clk);
        @(posedge clk);

        check_value("pslverr", apb_rsp.pslverr, 32'h0);
        reg_expect("CTRL", `BOX_ADDR_CTRL, 32'h0);
        reg_expect("OFFSET", `BOX_ADDR_OFFSET, 32'h0);
        reg_expect("STATUS", `BOX_ADDR_STATUS, 32'h0);
        reg_write(`BOX_ADDR_OFFSET, 32'h0000_00A5);
        reg_expect("OFFSET", `BOX_ADDR_OFFSET, 32'h0000_00A5);
        reg_write(`BOX_ADDR_CTRL, 32'h1);
        reg_expect("CTRL", `BOX_ADDR_CTRL, 32'h1);
        reg_write(`BOX_ADDR_CTRL, 32'h0);
        apb_xfer(1'b1, 4'hC, 32'h1, rd, err); // Unmapped.
        check_value("pslverr", err, 32'h1);
        apb_xfer(1'b0, 4'hC, 32'h0, rd, err);
        check_value("pslverr", err, 32'h1);

        drive_disabled(40);
        for (int f = 0; f < FRAMES; f++) begin
            reg_write(`BOX_ADDR_OFFSET, {24'h0, offs[f]});
            fill_frame(offs[f]);
            reg_write(`BOX_ADDR_CTRL, 32'h1);
            for (int y = 0; y < ROWS; y++) begin
                for (int x = 0; x < COLS; x++) begin
                    send_pixel(img[y][x], (y >= EDGE) && (x >= EDGE));
                end
            end
            end_stream();
            wait_results();
            reg_expect("STATUS", `BOX_ADDR_STATUS, 32'h0001_0000 | NRES);
            reg_write(`BOX_ADDR_STATUS, 32'h0001_0000);
            reg_expect("STATUS", `BOX_ADDR_STATUS, 32'h0);
            if (f == 0) begin
                reg_write(`BOX_ADDR_CTRL, 32'h0);
                drive_disabled(25); // Must not move the raster position.
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+src
src/box_pkg.sv
src/frame_ctrl.sv
src/line_buffer.sv
src/column_adder.sv
src/window_accumulator.sv
src/apb_regs.sv
src/adaptive_threshold_top.sv
tb/tb_clock.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line.
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f filelist.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && grep -q "^\*\*\* PASSED \*\*\*$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
